// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - logic/rv32i_pkg.sv
  - logic/ooo_pkg.sv
  - logic/inst_decoder.sv
  - logic/operand_bypass.sv
  - logic/issue_control.sv
  - logic/dispatch_regs.sv
  - logic/issue_top.sv
  - target: simulation
    files:
      - sim/tb_issue.sv

// ==== logic/dispatch_regs.sv ====
// registered dispatch to the ROB and the three reservation stations, one cycle after issue
`timescale 1ns/100ps

module dispatch_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_issue,
    input  ooo_pkg::unit_t      i_unit,
    input  ooo_pkg::alu_op_t    i_alu_op,
    input  logic                i_cmp_unsigned,
    input  logic                i_is_store,
    input  rv32i_pkg::funct3_t  i_funct3,
    input  rv32i_pkg::word_t    i_imm,
    input  logic                i_use_imm,
    input  logic                i_use_pc,
    input  logic                i_zero_rs1,
    input  rv32i_pkg::reg_idx_t i_rd,
    input  rv32i_pkg::word_t    i_pc,
    input  ooo_pkg::tag_t       i_qj,
    input  ooo_pkg::tag_t       i_qk,
    input  rv32i_pkg::word_t    i_vj,
    input  rv32i_pkg::word_t    i_vk,
    input  ooo_pkg::tag_t       i_tag,
    output logic                o_rob_valid,
    output ooo_pkg::rob_op_t    o_rob_op,
    output rv32i_pkg::reg_idx_t o_rob_dest,
    output logic                o_alu_valid,
    output rv32i_pkg::word_t    o_alu_vj,
    output rv32i_pkg::word_t    o_alu_vk,
    output ooo_pkg::tag_t       o_alu_qj,
    output ooo_pkg::tag_t       o_alu_qk,
    output ooo_pkg::alu_op_t    o_alu_op,
    output ooo_pkg::tag_t       o_alu_dest,
    output logic                o_cmp_valid,
    output rv32i_pkg::word_t    o_cmp_vj,
    output rv32i_pkg::word_t    o_cmp_vk,
    output ooo_pkg::tag_t       o_cmp_qj,
    output ooo_pkg::tag_t       o_cmp_qk,
    output logic                o_cmp_unsigned,
    output ooo_pkg::tag_t       o_cmp_dest,
    output logic                o_lsb_valid,
    output rv32i_pkg::word_t    o_lsb_vj,
    output rv32i_pkg::word_t    o_lsb_vk,
    output rv32i_pkg::word_t    o_lsb_a,
    output ooo_pkg::tag_t       o_lsb_qj,
    output ooo_pkg::tag_t       o_lsb_qk,
    output logic                o_lsb_store,
    output rv32i_pkg::funct3_t  o_lsb_funct,
    output ooo_pkg::tag_t       o_lsb_dest
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    word_t vj_op;
    word_t vk_op;
    tag_t  qj_op;
    tag_t  qk_op;

    // auipc adds to pc and lui to zero, neither waits on rs1
    assign vj_op = i_use_pc ? i_pc : (i_zero_rs1 ? '0 : i_vj);
    assign qj_op = (i_use_pc || i_zero_rs1) ? '0 : i_qj;
    assign vk_op = i_use_imm ? i_imm : i_vk;
    assign qk_op = i_use_imm ? '0 : i_qk;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rob_valid <= 1'b0;
            o_alu_valid <= 1'b0;
            o_cmp_valid <= 1'b0;
            o_lsb_valid <= 1'b0;
        end else begin
            o_rob_valid <= i_issue;
            o_alu_valid <= i_issue && (i_unit == UNIT_ALU);
            o_cmp_valid <= i_issue && (i_unit == UNIT_CMP);
            o_lsb_valid <= i_issue && (i_unit == UNIT_LSB);
        end
    end

    // payload only moves for the unit being issued to
    always_ff @(posedge clk) begin
        if (i_issue) begin
            o_rob_op   <= i_is_store ? ROB_ST : ROB_REG;
            o_rob_dest <= i_is_store ? '0 : i_rd;
        end
        if (i_issue && i_unit == UNIT_ALU) begin
            o_alu_vj   <= vj_op;
            o_alu_vk   <= vk_op;
            o_alu_qj   <= qj_op;
            o_alu_qk   <= qk_op;
            o_alu_op   <= i_alu_op;
            o_alu_dest <= i_tag;
        end
        if (i_issue && i_unit == UNIT_CMP) begin
            o_cmp_vj       <= vj_op;
            o_cmp_vk       <= vk_op;
            o_cmp_qj       <= qj_op;
            o_cmp_qk       <= qk_op;
            o_cmp_unsigned <= i_cmp_unsigned;
            o_cmp_dest     <= i_tag;
        end
        if (i_issue && i_unit == UNIT_LSB) begin
            o_lsb_vj    <= i_vj;
            o_lsb_qj    <= i_qj;
            o_lsb_vk    <= i_is_store ? i_vk : '0;  // store data, loads have none
            o_lsb_qk    <= i_is_store ? i_qk : '0;
            o_lsb_a     <= i_imm;
            o_lsb_store <= i_is_store;
            o_lsb_funct <= i_funct3;
            o_lsb_dest  <= i_tag;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({o_alu_valid, o_cmp_valid, o_lsb_valid}))
        else $error("more than one reservation station written in a cycle");

    // every ROB entry opened must go to exactly one unit
    assert property (@(posedge clk) disable iff (rst)
        o_rob_valid == (o_alu_valid || o_cmp_valid || o_lsb_valid))
        else $error("ROB entry and unit dispatch out of step");

endmodule

// ==== logic/inst_decoder.sv ====
// combinational RV32I decoder, splits the instruction word and picks the target unit and op
`timescale 1ns/100ps

module inst_decoder (
    input  rv32i_pkg::word_t    i_inst,
    output rv32i_pkg::reg_idx_t o_rs1,
    output rv32i_pkg::reg_idx_t o_rs2,
    output rv32i_pkg::reg_idx_t o_rd,
    output ooo_pkg::unit_t      o_unit,
    output ooo_pkg::alu_op_t    o_alu_op,
    output logic                o_cmp_unsigned,
    output logic                o_is_store,
    output rv32i_pkg::funct3_t  o_funct3,
    output rv32i_pkg::word_t    o_imm,
    output logic                o_use_imm,
    output logic                o_use_pc,
    output logic                o_zero_rs1,
    output logic                o_writes_rd
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    alt;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_u;

    // bit 30 turns add into sub only for register operands
    function automatic alu_op_t arith_op(funct3_t f3, logic alt_bit, logic is_reg);
        alu_op_t op;
        op = alu_op_t'(f3);
        if (f3 == F3_ADD && alt_bit && is_reg) begin
            op = ALU_SUB;
        end
        if (f3 == F3_SR && alt_bit) begin
            op = ALU_SRA;
        end
        return op;
    endfunction

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign alt    = i_inst[30];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];
    assign o_rd   = i_inst[11:7];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_u = {i_inst[31:12], 12'h000};

    assign o_funct3       = funct3;
    assign o_cmp_unsigned = (funct3 == F3_SLTU);
    assign o_writes_rd    = (o_unit != UNIT_NONE) && !o_is_store;

    always_comb begin
        o_unit     = UNIT_NONE;
        o_alu_op   = ALU_ADD;
        o_imm      = imm_i;
        o_use_imm  = 1'b0;
        o_use_pc   = 1'b0;
        o_zero_rs1 = 1'b0;
        o_is_store = 1'b0;
        case (opcode)
            OP_REG, OP_IMM: begin
                // set-less-than goes to the compare unit, everything else to the ALU
                if (funct3 == F3_SLT || funct3 == F3_SLTU) begin
                    o_unit = UNIT_CMP;
                end else begin
                    o_unit = UNIT_ALU;
                end
                o_alu_op  = arith_op(funct3, alt, opcode == OP_REG);
                o_use_imm = (opcode == OP_IMM);
            end
            OP_LUI: begin
                o_unit     = UNIT_ALU;
                o_imm      = imm_u;
                o_use_imm  = 1'b1;
                o_zero_rs1 = 1'b1;  // computed as 0 + imm
            end
            OP_AUIPC: begin
                o_unit    = UNIT_ALU;
                o_imm     = imm_u;
                o_use_imm = 1'b1;
                o_use_pc  = 1'b1;
            end
            OP_LOAD: begin
                o_unit = UNIT_LSB;
            end
            OP_STORE: begin
                o_unit     = UNIT_LSB;
                o_imm      = imm_s;
                o_is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/issue_control.sv ====
// combinational accept, discard and issue decision for the instruction at the queue head
`timescale 1ns/100ps

module issue_control (
    input  logic                i_inst_valid,
    input  ooo_pkg::unit_t      i_unit,
    input  logic                i_writes_rd,
    input  rv32i_pkg::reg_idx_t i_rd,
    input  ooo_pkg::tag_t       i_free_tag,
    input  logic                i_alu_ready,
    input  logic                i_cmp_ready,
    input  logic                i_lsb_ready,
    output logic                o_inst_ready,
    output logic                o_issue,
    output logic                o_load_tag,
    output ooo_pkg::tag_t       o_tag
);
    import ooo_pkg::*;

    logic discard;
    logic unit_ready;
    logic can_issue;

    always_comb begin
        case (i_unit)
            UNIT_ALU: unit_ready = i_alu_ready;
            UNIT_CMP: unit_ready = i_cmp_ready;
            UNIT_LSB: unit_ready = i_lsb_ready;
            default:  unit_ready = 1'b0;
        endcase
    end

    // unknown opcodes and writes to x0 have no effect, so they leave the queue at once
    assign discard   = (i_unit == UNIT_NONE) || (i_writes_rd && i_rd == '0);
    assign can_issue = (i_free_tag != '0) && unit_ready;  // free tag 0 means the ROB is full

    assign o_issue      = i_inst_valid && !discard && can_issue;
    assign o_inst_ready = i_inst_valid && (discard || can_issue);
    assign o_load_tag   = o_issue && i_writes_rd;
    assign o_tag        = o_load_tag ? i_free_tag : '0;

endmodule

// ==== logic/issue_top.sv ====
// issue stage top level, connects decoder, bypass, issue control and dispatch registers
`timescale 1ns/100ps

module issue_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_inst_valid,
    input  rv32i_pkg::word_t    i_pc,
    input  rv32i_pkg::word_t    i_inst,
    output logic                o_inst_ready,
    output rv32i_pkg::reg_idx_t o_rs1,
    output rv32i_pkg::reg_idx_t o_rs2,
    input  ooo_pkg::tag_t       i_reg_qj,
    input  ooo_pkg::tag_t       i_reg_qk,
    input  rv32i_pkg::word_t    i_reg_vj,
    input  rv32i_pkg::word_t    i_reg_vk,
    output logic                o_load_tag,
    output ooo_pkg::tag_t       o_tag,
    output rv32i_pkg::reg_idx_t o_rd,
    input  ooo_pkg::tag_t       i_free_tag,
    input  ooo_pkg::tag_mask_t  i_rob_ready,
    input  ooo_pkg::tag_vals_t  i_rob_vals,
    output logic                o_rob_valid,
    output ooo_pkg::rob_op_t    o_rob_op,
    output rv32i_pkg::reg_idx_t o_rob_dest,
    input  logic                i_alu_ready,
    input  logic                i_cmp_ready,
    input  logic                i_lsb_ready,
    output logic                o_alu_valid,
    output rv32i_pkg::word_t    o_alu_vj,
    output rv32i_pkg::word_t    o_alu_vk,
    output ooo_pkg::tag_t       o_alu_qj,
    output ooo_pkg::tag_t       o_alu_qk,
    output ooo_pkg::alu_op_t    o_alu_op,
    output ooo_pkg::tag_t       o_alu_dest,
    output logic                o_cmp_valid,
    output rv32i_pkg::word_t    o_cmp_vj,
    output rv32i_pkg::word_t    o_cmp_vk,
    output ooo_pkg::tag_t       o_cmp_qj,
    output ooo_pkg::tag_t       o_cmp_qk,
    output logic                o_cmp_unsigned,
    output ooo_pkg::tag_t       o_cmp_dest,
    output logic                o_lsb_valid,
    output rv32i_pkg::word_t    o_lsb_vj,
    output rv32i_pkg::word_t    o_lsb_vk,
    output rv32i_pkg::word_t    o_lsb_a,
    output ooo_pkg::tag_t       o_lsb_qj,
    output ooo_pkg::tag_t       o_lsb_qk,
    output logic                o_lsb_store,
    output rv32i_pkg::funct3_t  o_lsb_funct,
    output ooo_pkg::tag_t       o_lsb_dest
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    reg_idx_t dec_rd;
    unit_t    dec_unit;
    alu_op_t  dec_alu_op;
    logic     dec_cmp_unsigned;
    logic     dec_is_store;
    funct3_t  dec_funct3;
    word_t    dec_imm;
    logic     dec_use_imm;
    logic     dec_use_pc;
    logic     dec_zero_rs1;
    logic     dec_writes_rd;
    tag_t     byp_qj;
    tag_t     byp_qk;
    word_t    byp_vj;
    word_t    byp_vk;
    logic     issue;

    inst_decoder u_inst_decoder (
        .i_inst         (i_inst),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (dec_rd),
        .o_unit         (dec_unit),
        .o_alu_op       (dec_alu_op),
        .o_cmp_unsigned (dec_cmp_unsigned),
        .o_is_store     (dec_is_store),
        .o_funct3       (dec_funct3),
        .o_imm          (dec_imm),
        .o_use_imm      (dec_use_imm),
        .o_use_pc       (dec_use_pc),
        .o_zero_rs1     (dec_zero_rs1),
        .o_writes_rd    (dec_writes_rd)
    );

    operand_bypass u_operand_bypass (
        .o_qj (byp_qj),
        .o_qk (byp_qk),
        .o_vj (byp_vj),
        .o_vk (byp_vk),
        .*
    );

    issue_control u_issue_control (
        .i_inst_valid (i_inst_valid),
        .i_unit       (dec_unit),
        .i_writes_rd  (dec_writes_rd),
        .i_rd         (dec_rd),
        .i_free_tag   (i_free_tag),
        .i_alu_ready  (i_alu_ready),
        .i_cmp_ready  (i_cmp_ready),
        .i_lsb_ready  (i_lsb_ready),
        .o_inst_ready (o_inst_ready),
        .o_issue      (issue),
        .o_load_tag   (o_load_tag),
        .o_tag        (o_tag)
    );

    // the register file only sees rd when it is really being renamed
    assign o_rd = o_load_tag ? dec_rd : '0;

    // stores also take a ROB entry, so the free tag goes to dispatch directly
    dispatch_regs u_dispatch_regs (
        .i_issue        (issue),
        .i_unit         (dec_unit),
        .i_alu_op       (dec_alu_op),
        .i_cmp_unsigned (dec_cmp_unsigned),
        .i_is_store     (dec_is_store),
        .i_funct3       (dec_funct3),
        .i_imm          (dec_imm),
        .i_use_imm      (dec_use_imm),
        .i_use_pc       (dec_use_pc),
        .i_zero_rs1     (dec_zero_rs1),
        .i_rd           (dec_rd),
        .i_qj           (byp_qj),
        .i_qk           (byp_qk),
        .i_vj           (byp_vj),
        .i_vk           (byp_vk),
        .i_tag          (i_free_tag),
        .*
    );

    // a rename at the register file is always followed by the matching ROB entry
    assert property (@(posedge clk) disable iff (rst)
        o_load_tag |=> o_rob_valid && o_rob_dest == $past(o_rd))
        else $error("renamed register without a matching ROB entry");

endmodule

// ==== logic/ooo_pkg.sv ====
// out-of-order machine types shared by the issue stage modules and the testbench
package ooo_pkg;

    localparam int NUM_TAGS = 8;
    localparam int TAG_W    = $clog2(NUM_TAGS);

    // tag 0 never names a ROB entry, it marks an operand whose value is present
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [NUM_TAGS-1:0] tag_mask_t;

    // result value held by the ROB for each tag
    typedef rv32i_pkg::word_t [NUM_TAGS-1:0] tag_vals_t;

    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_CMP  = 2'd2,
        UNIT_LSB  = 2'd3
    } unit_t;

    // codes follow funct3 so most ops are a direct cast, sub and sra take the
    // two codes that slt and sltu leave free
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SLL = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SRA = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SRL = 3'd5,
        ALU_OR  = 3'd6,
        ALU_AND = 3'd7
    } alu_op_t;

    typedef enum logic {
        ROB_REG = 1'b0,
        ROB_ST  = 1'b1
    } rob_op_t;

endpackage

// ==== logic/operand_bypass.sv ====
// combinational forwarding of finished ROB results into both source operands
`timescale 1ns/100ps

module operand_bypass (
    input  ooo_pkg::tag_t      i_reg_qj,
    input  ooo_pkg::tag_t      i_reg_qk,
    input  rv32i_pkg::word_t   i_reg_vj,
    input  rv32i_pkg::word_t   i_reg_vk,
    input  ooo_pkg::tag_mask_t i_rob_ready,
    input  ooo_pkg::tag_vals_t i_rob_vals,
    output ooo_pkg::tag_t      o_qj,
    output ooo_pkg::tag_t      o_qk,
    output rv32i_pkg::word_t   o_vj,
    output rv32i_pkg::word_t   o_vk
);
    import ooo_pkg::*;

    logic hit_j;
    logic hit_k;

    // the register file still waits on the tag, but the ROB already has the value
    assign hit_j = (i_reg_qj != '0) && i_rob_ready[i_reg_qj];
    assign hit_k = (i_reg_qk != '0) && i_rob_ready[i_reg_qk];

    assign o_qj = hit_j ? '0 : i_reg_qj;
    assign o_vj = hit_j ? i_rob_vals[i_reg_qj] : i_reg_vj;

    assign o_qk = hit_k ? '0 : i_reg_qk;
    assign o_vk = hit_k ? i_rob_vals[i_reg_qk] : i_reg_vk;

endmodule

// ==== logic/rv32i_pkg.sv ====
// RV32I instruction set definitions, imported by the decoder and the testbench
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // only the opcodes this issue stage accepts, control flow is not handled
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP_REG   = 7'b0110011;
    localparam opcode_t OP_LUI   = 7'b0110111;
    localparam opcode_t OP_AUIPC = 7'b0010111;
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    localparam funct3_t F3_ADD  = 3'b000;  // also sub when bit 30 is set in OP
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl, or sra with bit 30
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

endpackage

// ==== sim/tb_issue.sv ====
// self-checking testbench for the issue stage, applies a stimulus table and checks both cycles
`timescale 1ns/100ps

module tb_issue;
    import rv32i_pkg::*;
    import ooo_pkg::*;

    typedef struct {
        word_t     inst;
        word_t     pc;
        tag_t      qj;
        word_t     vj;
        tag_t      qk;
        word_t     vk;
        tag_mask_t mask;
        tag_t      free;
        logic      alu_r;
        logic      cmp_r;
        logic      lsb_r;
        logic      e_acc;
        unit_t     e_unit;
        alu_op_t   e_op;
        logic      e_uns;
        logic      e_store;
        word_t     e_vj;
        tag_t      e_qj;
        word_t     e_vk;
        tag_t      e_qk;
        word_t     e_a;
        logic      e_ltag;
    } row_t;

    logic clk, rst, i_inst_valid, i_alu_ready, i_cmp_ready, i_lsb_ready;
    word_t i_pc, i_inst, i_reg_vj, i_reg_vk;
    tag_t i_reg_qj, i_reg_qk, i_free_tag;
    tag_mask_t i_rob_ready;
    tag_vals_t i_rob_vals;
    logic o_inst_ready, o_load_tag, o_rob_valid, o_alu_valid, o_cmp_valid, o_lsb_valid;
    logic o_cmp_unsigned, o_lsb_store;
    reg_idx_t o_rs1, o_rs2, o_rd, o_rob_dest;
    tag_t o_tag, o_alu_qj, o_alu_qk, o_alu_dest, o_cmp_qj, o_cmp_qk, o_cmp_dest;
    tag_t o_lsb_qj, o_lsb_qk, o_lsb_dest;
    rob_op_t o_rob_op;
    alu_op_t o_alu_op;
    word_t o_alu_vj, o_alu_vk, o_cmp_vj, o_cmp_vk, o_lsb_vj, o_lsb_vk, o_lsb_a;
    funct3_t o_lsb_funct;

    row_t  rows[$];
    row_t  r;
    row_t  cur;
    logic  [31:0] lfsr = 32'h7ea2_87ec;
    logic  table_built = 1'b0;

    issue_top i_issue_top (.*);

    // the register file model answers from the row being applied and x0 always reads 0 with no tag
    assign i_reg_qj = (o_rs1 == '0) ? '0 : cur.qj;
    assign i_reg_vj = (o_rs1 == '0) ? '0 : cur.vj;
    assign i_reg_qk = (o_rs2 == '0) ? '0 : cur.qk;
    assign i_reg_vk = (o_rs2 == '0) ? '0 : cur.vk;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci LFSR with taps 32 22 2 1 that steps once per bit taken
    function automatic word_t rand_bits(int n);
        word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic word_t r_type(logic alt, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                     reg_idx_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, funct3_t f3, reg_idx_t rd,
                                     opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    task automatic fail(string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) fail($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_tag(tag_t got, tag_t exp, string what);
        if (got !== exp) fail($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_unit(unit_t got, unit_t exp, string what);
        if (got !== exp) fail($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_op(alu_op_t got, alu_op_t exp, string what);
        if (got !== exp) fail($sformatf("%s got %s expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    // fills r with random operands and the defaults of an issued register-register instruction
    task automatic start_row(word_t inst, unit_t unit, tag_t free);
        r.inst   = inst;
        r.pc     = rand_bits(32);
        r.qj     = '0;
        r.vj     = rand_bits(32);
        r.qk     = '0;
        r.vk     = rand_bits(32);
        r.mask   = '0;
        r.free   = free;
        r.alu_r  = 1'b1;
        r.cmp_r  = 1'b1;
        r.lsb_r  = 1'b1;
        r.e_acc  = 1'b1;
        r.e_unit = unit;
        r.e_op   = ALU_ADD;
        r.e_uns  = 1'b0;
        r.e_store = 1'b0;
        r.e_vj   = r.vj;
        r.e_qj   = '0;
        r.e_vk   = r.vk;
        r.e_qk   = '0;
        r.e_a    = '0;
        r.e_ltag = (unit != UNIT_NONE);
    endtask

    task automatic add_op(funct3_t f3, logic alt, alu_op_t op, tag_t free);
        start_row(r_type(alt, 5'd2, 5'd1, f3, 5'd5), UNIT_ALU, free);
        r.e_op = op;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_op(F3_ADD, 1'b0, ALU_ADD, 3'd1);
        add_op(F3_ADD, 1'b1, ALU_SUB, 3'd2);
        add_op(F3_SLL, 1'b0, ALU_SLL, 3'd3);
        add_op(F3_SR,  1'b0, ALU_SRL, 3'd4);
        add_op(F3_SR,  1'b1, ALU_SRA, 3'd5);
        add_op(F3_XOR, 1'b0, ALU_XOR, 3'd6);
        add_op(F3_OR,  1'b0, ALU_OR,  3'd7);
        add_op(F3_AND, 1'b0, ALU_AND, 3'd1);
        // rs1 tag 4 is still pending and rs2 tag 3 is finished in the ROB
        add_op(F3_ADD, 1'b0, ALU_ADD, 3'd2);
        rows[$].qj   = 3'd4;
        rows[$].qk   = 3'd3;
        rows[$].mask = 8'b0000_1000;
        rows[$].e_qj = 3'd4;
        rows[$].e_vk = i_rob_vals[3];
        // rs1 tag 3 is finished in the ROB, rs2 tag 6 is still pending
        add_op(F3_XOR, 1'b0, ALU_XOR, 3'd7);
        rows[$].qj   = 3'd3;
        rows[$].qk   = 3'd6;
        rows[$].mask = 8'b1000_1000;
        rows[$].e_vj = i_rob_vals[3];
        rows[$].e_qk = 3'd6;
        start_row(i_type(12'hffb, 5'd1, F3_ADD, 5'd6, OP_IMM), UNIT_ALU, 3'd3);
        r.e_vk = 32'hffff_fffb;
        rows.push_back(r);
        start_row(i_type(12'h7ff, 5'd1, F3_XOR, 5'd6, OP_IMM), UNIT_ALU, 3'd4);
        r.e_op = ALU_XOR;
        r.e_vk = 32'h0000_07ff;
        rows.push_back(r);
        start_row(i_type(12'h403, 5'd1, F3_SR, 5'd6, OP_IMM), UNIT_ALU, 3'd5);
        r.e_op = ALU_SRA;
        r.e_vk = 32'h0000_0403;
        rows.push_back(r);
        start_row({20'habcde, 5'd7, OP_LUI}, UNIT_ALU, 3'd6);
        r.qj   = 3'd2;  // lui must ignore whatever the rs1 field reads
        r.e_vj = '0;
        r.e_vk = 32'habcd_e000;
        rows.push_back(r);
        start_row({20'h12345, 5'd9, OP_AUIPC}, UNIT_ALU, 3'd7);
        r.e_vj = r.pc;
        r.e_vk = 32'h1234_5000;
        rows.push_back(r);
        start_row(r_type(1'b0, 5'd2, 5'd1, F3_SLT, 5'd10), UNIT_CMP, 3'd1);
        rows.push_back(r);
        start_row(r_type(1'b0, 5'd2, 5'd1, F3_SLTU, 5'd10), UNIT_CMP, 3'd2);
        r.e_uns = 1'b1;
        rows.push_back(r);
        start_row(i_type(12'hfff, 5'd1, F3_SLT, 5'd11, OP_IMM), UNIT_CMP, 3'd3);
        r.e_vk = 32'hffff_ffff;
        rows.push_back(r);
        start_row(i_type(12'h00c, 5'd1, F3_SLTU, 5'd11, OP_IMM), UNIT_CMP, 3'd4);
        r.e_uns = 1'b1;
        r.e_vk  = 32'h0000_000c;
        rows.push_back(r);
        start_row(i_type(12'h010, 5'd1, 3'b010, 5'd8, OP_LOAD), UNIT_LSB, 3'd5);
        r.e_vk = '0;
        r.e_a  = 32'h0000_0010;
        rows.push_back(r);
        start_row(s_type(12'hff8, 5'd2, 5'd1, 3'b010), UNIT_LSB, 3'd6);
        r.qk      = 3'd5;
        r.e_qk    = 3'd5;
        r.e_store = 1'b1;
        r.e_a     = 32'hffff_fff8;
        r.e_ltag  = 1'b0;
        rows.push_back(r);
        // back-pressure rows are held off and leave no trace
        start_row(r_type(1'b0, 5'd2, 5'd1, F3_ADD, 5'd5), UNIT_NONE, 3'd1);
        r.alu_r = 1'b0;
        r.e_acc = 1'b0;
        rows.push_back(r);
        start_row(r_type(1'b0, 5'd2, 5'd1, F3_ADD, 5'd5), UNIT_NONE, 3'd0);
        r.e_acc = 1'b0;
        rows.push_back(r);
        start_row(i_type(12'h004, 5'd1, 3'b010, 5'd8, OP_LOAD), UNIT_NONE, 3'd2);
        r.lsb_r = 1'b0;
        r.e_acc = 1'b0;
        rows.push_back(r);
        start_row(r_type(1'b0, 5'd2, 5'd1, F3_ADD, 5'd0), UNIT_NONE, 3'd3);
        rows.push_back(r);
        start_row({25'h0, 7'b1101111}, UNIT_NONE, 3'd0);  // jal is unknown here
        rows.push_back(r);
    endtask

    task automatic check_dispatch(row_t t);
        unit_t seen;
        seen = o_alu_valid ? UNIT_ALU : (o_cmp_valid ? UNIT_CMP :
               (o_lsb_valid ? UNIT_LSB : UNIT_NONE));
        check_unit(seen, t.e_unit, "dispatched unit");
        check_bit(o_rob_valid, t.e_unit != UNIT_NONE, "rob valid");
        if (t.e_unit != UNIT_NONE) begin
            check_bit(o_rob_op == ROB_ST, t.e_store, "rob op is store");
            check_word(32'(o_rob_dest), t.e_store ? 32'd0 : 32'(t.inst[11:7]), "rob dest");
        end
        if (t.e_unit == UNIT_ALU) begin
            check_word(o_alu_vj, t.e_vj, "alu vj");
            check_word(o_alu_vk, t.e_vk, "alu vk");
            check_tag(o_alu_qj, t.e_qj, "alu qj");
            check_tag(o_alu_qk, t.e_qk, "alu qk");
            check_op(o_alu_op, t.e_op, "alu op");
            check_tag(o_alu_dest, t.free, "alu dest");
        end else if (t.e_unit == UNIT_CMP) begin
            check_word(o_cmp_vj, t.e_vj, "cmp vj");
            check_word(o_cmp_vk, t.e_vk, "cmp vk");
            check_tag(o_cmp_qj, t.e_qj, "cmp qj");
            check_tag(o_cmp_qk, t.e_qk, "cmp qk");
            check_bit(o_cmp_unsigned, t.e_uns, "cmp unsigned");
            check_tag(o_cmp_dest, t.free, "cmp dest");
        end else if (t.e_unit == UNIT_LSB) begin
            check_word(o_lsb_vj, t.e_vj, "lsb vj");
            check_word(o_lsb_vk, t.e_vk, "lsb vk");
            check_tag(o_lsb_qj, t.e_qj, "lsb qj");
            check_tag(o_lsb_qk, t.e_qk, "lsb qk");
            check_word(o_lsb_a, t.e_a, "lsb address offset");
            check_bit(o_lsb_store, t.e_store, "lsb store");
            check_word(32'(o_lsb_funct), 32'(t.inst[14:12]), "lsb funct");
            check_tag(o_lsb_dest, t.free, "lsb dest");
        end
    endtask

    initial begin
        rst = 1'b1;
        i_inst_valid = 1'b0;
        i_pc = '0;
        i_inst = '0;
        i_free_tag = '0;
        i_rob_ready = '0;
        i_alu_ready = 1'b0;
        i_cmp_ready = 1'b0;
        i_lsb_ready = 1'b0;
        cur.qj = '0;
        cur.vj = '0;
        cur.qk = '0;
        cur.vk = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            i_rob_vals[i] = rand_bits(32);
        end
        build_table();
        table_built = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            cur          = rows[i];
            i_inst_valid = 1'b1;
            i_inst       = cur.inst;
            i_pc         = cur.pc;
            i_rob_ready  = cur.mask;
            i_free_tag   = cur.free;
            i_alu_ready  = cur.alu_r;
            i_cmp_ready  = cur.cmp_r;
            i_lsb_ready  = cur.lsb_r;
            #2;
            check_bit(o_inst_ready, cur.e_acc, $sformatf("row %0d inst ready", i));
            check_bit(o_load_tag, cur.e_ltag, $sformatf("row %0d load tag", i));
            check_tag(o_tag, cur.e_ltag ? cur.free : '0, $sformatf("row %0d rename tag", i));
            check_word(32'(o_rd), cur.e_ltag ? 32'(cur.inst[11:7]) : 32'd0,
                       $sformatf("row %0d rename rd", i));
            check_word(32'(o_rs1), 32'(cur.inst[19:15]), $sformatf("row %0d rs1 index", i));
            check_word(32'(o_rs2), 32'(cur.inst[24:20]), $sformatf("row %0d rs2 index", i));
            // the dispatch pulse of the previous row lasts a single cycle
            check_bit(o_rob_valid, 1'b0, $sformatf("row %0d stale rob valid", i));
            check_bit(o_alu_valid || o_cmp_valid || o_lsb_valid, 1'b0,
                      $sformatf("row %0d stale unit valid", i));
            @(posedge clk);
            #1 i_inst_valid = 1'b0;
            #2 check_dispatch(cur);
        end
        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

    // each row takes two cycles, ten per row leaves a wide margin
    initial begin
        wait (table_built);
        #((rows.size() * 10 + 3) * 4);
        $display("watchdog expired before the stimulus table finished");
        $display("RESULT: FAIL");
        $fatal(1);
    end

endmodule

// ==== tb.f ====
logic/rv32i_pkg.sv
logic/ooo_pkg.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/issue_control.sv
logic/dispatch_regs.sv
logic/issue_top.sv
sim/tb_issue.sv
